/* rtl/id_consts.svh */
// Sizes, widths and opcode values of the decode stage.
// The queue depth must stay at least ID_STOP_FREE + 1.
// Only the integer subset listed here is decoded, anything else is reserved.
`ifndef ID_CONSTS_SVH
`define ID_CONSTS_SVH

`define ID_QUEUE_DEPTH 4      // instruction queue entries
`define ID_STOP_FREE   2      // stop fetch below this many free entries
`define ID_XLEN        32     // data word width
`define ID_REG_BITS    5      // register number width

// primary opcodes
`define ID_OP_RTYPE 6'b000000
`define ID_OP_ADDIU 6'b001001
`define ID_OP_ORI   6'b001101
`define ID_OP_LUI   6'b001111
`define ID_OP_LW    6'b100011
`define ID_OP_SW    6'b101011
`define ID_OP_BEQ   6'b000100

// function field of r-type
`define ID_FN_ADDU 6'b100001
`define ID_FN_SUBU 6'b100011
`define ID_FN_AND  6'b100100
`define ID_FN_OR   6'b100101
`define ID_FN_SLT  6'b101010

`endif

/* rtl/idPkg.sv */
// Shared types of the decode stage.
// Widths come from the constants header, so both must be compiled together.
`default_nettype none

`include "id_consts.svh"

package idPkg;

    ////////////////////////////////////////////////////////////////////////////
    // basic words
    ////////////////////////////////////////////////////////////////////////////
    typedef logic [`ID_XLEN-1:0]     word_t;
    typedef logic [`ID_REG_BITS-1:0] regNum_t;   // 0 means no register

    ////////////////////////////////////////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT,
        ALU_LUI    // pass the shifted immediate
    } aluOp_t;

    // where execute takes an operand from
    typedef enum logic [1:0] {
        FWD_REG,   // register file, includes write-back bypass
        FWD_EXE,
        FWD_MEM
    } fwdSel_t;

    ////////////////////////////////////////////////////////////////////////////
    // queue payload
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        word_t pc;
        word_t inst;
    } queueEntry_t;

endpackage

`default_nettype wire

/* rtl/idIfs.sv */
// Interfaces inside the decode stage.
// queueIf: pop may only be raised while headValid is high.
// stageIf: a write number of zero means the stage writes nothing.
`default_nettype none

interface queueIf;
    logic                headValid;
    idPkg::queueEntry_t  head;
    logic                pop;        // entry leaves on the edge

    modport queue  (output headValid, output head, input pop);
    modport decode (input head);
    modport issue  (input headValid, output pop);
endinterface

interface stageIf;
    idPkg::regNum_t  exeWriteNum;
    logic            exeReady;       // exe result usable next cycle
    idPkg::regNum_t  memWriteNum;
    logic            memReady;

    modport src  (output exeWriteNum, output exeReady,
                  output memWriteNum, output memReady);
    modport sink (input exeWriteNum, input exeReady,
                  input memWriteNum, input memReady);
endinterface

`default_nettype wire

/* rtl/instQueue.sv */
// Circular FIFO of fetched instructions with their PCs.
// A push into a full queue is dropped; fetch should obey stopFetch_o.
// flush_i empties the queue at the next edge and wins over push and pop.
// stopFetch_o is registered from the occupancy left by each edge.
`default_nettype none

`include "id_consts.svh"

module instQueue import idPkg::*; (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        flush_i,
    input  logic        fetchValid_i,
    input  queueEntry_t fetchEntry_i,
    output logic        stopFetch_o,
    queueIf.queue       q
);
    localparam int DEPTH = `ID_QUEUE_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    queueEntry_t         mem [DEPTH];
    logic [PTR_W-1:0]    rdPtr;
    logic [PTR_W-1:0]    wrPtr;
    logic [CNT_W-1:0]    count;
    logic [CNT_W-1:0]    countNext;
    logic                doPush;
    logic                doPop;

    assign doPush = fetchValid_i && (count != CNT_W'(DEPTH));  // full drops it
    assign doPop  = q.pop && q.headValid;

    assign countNext = flush_i ? '0 : count + CNT_W'(doPush) - CNT_W'(doPop);

    ////////////////////////////////////////////////////////////////////////////
    // pointers and occupancy
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush)
                wrPtr <= (wrPtr == PTR_W'(DEPTH - 1)) ? '0 : wrPtr + 1'b1;
            if (doPop)
                rdPtr <= (rdPtr == PTR_W'(DEPTH - 1)) ? '0 : rdPtr + 1'b1;
            count <= countNext;
        end
    end

    // free entries after this edge below the limit
    always_ff @(posedge clk_i) begin
        if (rst_i)
            stopFetch_o <= 1'b0;
        else
            stopFetch_o <= countNext > CNT_W'(DEPTH - `ID_STOP_FREE);
    end

    always_ff @(posedge clk_i) begin
        if (doPush && !flush_i)
            mem[wrPtr] <= fetchEntry_i;  // payload only
    end

    assign q.headValid = (count != '0);
    assign q.head      = mem[rdPtr];

endmodule

`default_nettype wire

/* rtl/decoder.sv */
// Decoder for the integer subset: addu subu and or slt, addiu ori lui,
// lw sw and beq. Purely combinational on the queue head.
// Any other opcode or function raises reservedInst_o with no reads or write.
`default_nettype none

`include "id_consts.svh"

module decoder import idPkg::*; (
    queueIf.decode    q,
    output aluOp_t    aluOp_o,
    output regNum_t   rsNum_o,
    output regNum_t   rtNum_o,
    output logic      rsNeeded_o,
    output logic      rtNeeded_o,
    output regNum_t   writeNum_o,
    output word_t     imm_o,
    output logic      op1IsImm_o,
    output logic      memReq_o,
    output logic      memWrite_o,
    output logic      isBranch_o,
    output logic      reservedInst_o
);
    word_t       inst;
    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] immField;
    regNum_t     rdNum;
    word_t       immSext;
    word_t       immZext;
    word_t       immHigh;

    assign inst     = q.head.inst;
    assign opcode   = inst[31:26];
    assign funct    = inst[5:0];
    assign immField = inst[15:0];
    assign rdNum    = inst[15:11];

    assign rsNum_o = inst[25:21];   // fields pass through, needs qualify them
    assign rtNum_o = inst[20:16];

    assign immSext = {{(`ID_XLEN-16){immField[15]}}, immField};
    assign immZext = {{(`ID_XLEN-16){1'b0}}, immField};
    assign immHigh = {immField, 16'b0};

    always_comb begin
        aluOp_o        = ALU_ADD;
        rsNeeded_o     = 1'b0;
        rtNeeded_o     = 1'b0;
        writeNum_o     = '0;
        imm_o          = immSext;
        op1IsImm_o     = 1'b0;
        memReq_o       = 1'b0;
        memWrite_o     = 1'b0;
        isBranch_o     = 1'b0;
        reservedInst_o = 1'b0;

        case (opcode)
            `ID_OP_RTYPE: begin
                rsNeeded_o = 1'b1;
                rtNeeded_o = 1'b1;
                writeNum_o = rdNum;
                case (funct)
                    `ID_FN_ADDU: aluOp_o = ALU_ADD;
                    `ID_FN_SUBU: aluOp_o = ALU_SUB;
                    `ID_FN_AND:  aluOp_o = ALU_AND;
                    `ID_FN_OR:   aluOp_o = ALU_OR;
                    `ID_FN_SLT:  aluOp_o = ALU_SLT;
                    default: begin
                        rsNeeded_o     = 1'b0;  // unknown function
                        rtNeeded_o     = 1'b0;
                        writeNum_o     = '0;
                        reservedInst_o = 1'b1;
                    end
                endcase
            end
            `ID_OP_ADDIU, `ID_OP_LW: begin
                rsNeeded_o = 1'b1;
                writeNum_o = rtNum_o;
                op1IsImm_o = 1'b1;
                memReq_o   = (opcode == `ID_OP_LW);
            end
            `ID_OP_ORI: begin
                aluOp_o    = ALU_OR;
                rsNeeded_o = 1'b1;
                writeNum_o = rtNum_o;
                imm_o      = immZext;
                op1IsImm_o = 1'b1;
            end
            `ID_OP_LUI: begin
                aluOp_o    = ALU_LUI;   // no register read
                writeNum_o = rtNum_o;
                imm_o      = immHigh;
                op1IsImm_o = 1'b1;
            end
            `ID_OP_SW: begin
                rsNeeded_o = 1'b1;      // base
                rtNeeded_o = 1'b1;      // store data
                op1IsImm_o = 1'b1;
                memReq_o   = 1'b1;
                memWrite_o = 1'b1;
            end
            `ID_OP_BEQ: begin
                aluOp_o    = ALU_SUB;   // compare rs with rt
                rsNeeded_o = 1'b1;
                rtNeeded_o = 1'b1;
                isBranch_o = 1'b1;
            end
            default: reservedInst_o = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/regFile.sv */
// Two read ports, one write port, 31 writable registers.
// Register 0 reads zero and ignores writes.
// A read of the register written this cycle returns the new data.
`default_nettype none

module regFile import idPkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  regNum_t rsNum_i,
    input  regNum_t rtNum_i,
    input  logic    wbWriteEn_i,
    input  regNum_t wbWriteNum_i,
    input  word_t   wbWriteData_i,
    output word_t   rsData_o,
    output word_t   rtData_o
);
    word_t regs [31:1];

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 1; i < 32; i++)
                regs[i] <= '0;
        end else if (wbWriteEn_i && wbWriteNum_i != '0) begin
            regs[wbWriteNum_i] <= wbWriteData_i;
        end
    end

    // zero register first, then same-cycle bypass
    assign rsData_o = (rsNum_i == '0) ? '0 :
                      (wbWriteEn_i && wbWriteNum_i == rsNum_i) ? wbWriteData_i :
                      regs[rsNum_i];
    assign rtData_o = (rtNum_i == '0) ? '0 :
                      (wbWriteEn_i && wbWriteNum_i == rtNum_i) ? wbWriteData_i :
                      regs[rtNum_i];

endmodule

`default_nettype wire

/* rtl/issueCtrl.sv */
// Forwarding select, hazard stall and the issue handshake.
// Execute wins over memory when both write the same register.
// Combinational; flush_i only masks the valid, the queue does the emptying.
`default_nettype none

module issueCtrl import idPkg::*; (
    input  logic      flush_i,
    input  logic      exeAllowin_i,
    input  regNum_t   rsNum_i,
    input  regNum_t   rtNum_i,
    input  logic      rsNeeded_i,
    input  logic      rtNeeded_i,
    stageIf.sink      stage,
    queueIf.issue     q,
    output fwdSel_t   fwdSel0_o,
    output fwdSel_t   fwdSel1_o,
    output logic      issueValid_o
);
    logic stall;

    function automatic fwdSel_t pickSrc(input regNum_t num, input logic needed,
                                        input regNum_t exeNum, input regNum_t memNum);
        if (!needed || num == '0)
            return FWD_REG;
        else if (num == exeNum)
            return FWD_EXE;
        else if (num == memNum)
            return FWD_MEM;
        else
            return FWD_REG;
    endfunction

    // chosen stage has no result yet
    function automatic logic srcStall(input fwdSel_t sel, input logic exeRdy,
                                      input logic memRdy);
        return (sel == FWD_EXE && !exeRdy) || (sel == FWD_MEM && !memRdy);
    endfunction

    assign fwdSel0_o = pickSrc(rsNum_i, rsNeeded_i, stage.exeWriteNum, stage.memWriteNum);
    assign fwdSel1_o = pickSrc(rtNum_i, rtNeeded_i, stage.exeWriteNum, stage.memWriteNum);

    assign stall = srcStall(fwdSel0_o, stage.exeReady, stage.memReady) ||
                   srcStall(fwdSel1_o, stage.exeReady, stage.memReady);

    assign issueValid_o = q.headValid && !stall && !flush_i;
    assign q.pop        = issueValid_o && exeAllowin_i;  // transfer edge

endmodule

`default_nettype wire

/* rtl/idStage.sv */
// Decode stage top: queue, decoder, register file and issue control.
// Fetch must stop pushing while stopFetch_o is high.
// Issue transfers on an edge with issueValid_o and exeAllowin_i both high.
`default_nettype none

module idStage import idPkg::*; (
    input  logic    clk_i,
    input  logic    rst_i,
    input  logic    flush_i,
    input  logic    fetchValid_i,
    input  word_t   fetchInst_i,
    input  word_t   fetchPc_i,
    input  logic    exeAllowin_i,
    input  regNum_t exeWriteNum_i,
    input  logic    exeReady_i,
    input  regNum_t memWriteNum_i,
    input  logic    memReady_i,
    input  logic    wbWriteEn_i,
    input  regNum_t wbWriteNum_i,
    input  word_t   wbWriteData_i,
    output logic    stopFetch_o,
    output logic    issueValid_o,
    output word_t   pc_o,
    output aluOp_t  aluOp_o,
    output regNum_t writeNum_o,
    output word_t   rsData_o,
    output word_t   rtData_o,
    output fwdSel_t fwdSel0_o,
    output fwdSel_t fwdSel1_o,
    output word_t   imm_o,
    output logic    op1IsImm_o,
    output logic    memReq_o,
    output logic    memWrite_o,
    output logic    isBranch_o,
    output logic    reservedInst_o
);
    queueIf      q ();
    stageIf      stage ();
    queueEntry_t fetchEntry;
    regNum_t     rsNum;
    regNum_t     rtNum;
    logic        rsNeeded;
    logic        rtNeeded;

    assign fetchEntry        = '{pc: fetchPc_i, inst: fetchInst_i};
    assign stage.exeWriteNum = exeWriteNum_i;
    assign stage.exeReady    = exeReady_i;
    assign stage.memWriteNum = memWriteNum_i;
    assign stage.memReady    = memReady_i;
    assign pc_o              = q.head.pc;

    instQueue queue0 (.clk_i, .rst_i, .flush_i, .fetchValid_i,
                      .fetchEntry_i(fetchEntry), .stopFetch_o, .q(q.queue));

    decoder dec0 (.q(q.decode), .aluOp_o, .rsNum_o(rsNum), .rtNum_o(rtNum),
                  .rsNeeded_o(rsNeeded), .rtNeeded_o(rtNeeded), .writeNum_o, .imm_o,
                  .op1IsImm_o, .memReq_o, .memWrite_o, .isBranch_o, .reservedInst_o);

    regFile rf0 (.clk_i, .rst_i, .rsNum_i(rsNum), .rtNum_i(rtNum), .wbWriteEn_i,
                 .wbWriteNum_i, .wbWriteData_i, .rsData_o, .rtData_o);

    issueCtrl issue0 (.flush_i, .exeAllowin_i, .rsNum_i(rsNum), .rtNum_i(rtNum),
                      .rsNeeded_i(rsNeeded), .rtNeeded_i(rtNeeded), .stage(stage.sink),
                      .q(q.issue), .fwdSel0_o, .fwdSel1_o, .issueValid_o);

endmodule

`default_nettype wire

/* tests/idStage_props.sv */
// Handshake properties of the decode stage, bound into every idStage.
// Stability covers the decoded fields only, since register data may
// change through write-back while an instruction waits.
`default_nettype none

module idStageProps import idPkg::*; (
    input logic    clk_i,
    input logic    rst_i,
    input logic    flush_i,
    input logic    exeAllowin_i,
    input logic    issueValid_o,
    input word_t   pc_o,
    input aluOp_t  aluOp_o,
    input regNum_t writeNum_o,
    input word_t   imm_o,
    input fwdSel_t fwdSel0_o,
    input fwdSel_t fwdSel1_o
);
    timeunit 1ns;
    timeprecision 1ps;

    resetQuiet: assert property (@(posedge clk_i) rst_i && $past(rst_i) |-> !issueValid_o)
        else $error("issueValid_o high during reset");

    // offered instruction stays put until taken or flushed
    holdSteady: assert property (@(posedge clk_i) disable iff (rst_i)
        issueValid_o && !exeAllowin_i |=> flush_i ||
            (issueValid_o && $stable(pc_o) && $stable(aluOp_o) && $stable(writeNum_o) &&
             $stable(imm_o) && $stable(fwdSel0_o) && $stable(fwdSel1_o)))
        else $error("issue outputs changed under back-pressure");

    // no offer while flushing, and the queue is empty one cycle later
    flushMasks: assert property (@(posedge clk_i)
        flush_i |-> !issueValid_o ##1 !issueValid_o)
        else $error("issueValid_o high during or right after a flush");

endmodule

bind idStage idStageProps props0 (.clk_i(clk_i), .rst_i(rst_i), .flush_i(flush_i),
    .exeAllowin_i(exeAllowin_i), .issueValid_o(issueValid_o), .pc_o(pc_o),
    .aluOp_o(aluOp_o), .writeNum_o(writeNum_o), .imm_o(imm_o),
    .fwdSel0_o(fwdSel0_o), .fwdSel1_o(fwdSel1_o));

`default_nettype wire

/* tests/idStageTb.sv */
// Directed testbench for the decode stage.
// Inputs change 1 ns after the rising edge, outputs are checked at the falling edge.
// Between tests the stage inputs show no hazard and exeAllowin_i is high.
// The watchdog allows 200 clock cycles per test.
`default_nettype none

`include "id_consts.svh"

module idStageTb import idPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_TESTS  = 5;
    localparam int STOP_AFTER = `ID_QUEUE_DEPTH - `ID_STOP_FREE + 1;  // pushes until stop

    logic    clk_i = 1'b0;
    logic    rst_i;
    logic    flush_i;
    logic    fetchValid_i;
    word_t   fetchInst_i;
    word_t   fetchPc_i;
    logic    exeAllowin_i;
    regNum_t exeWriteNum_i;
    logic    exeReady_i;
    regNum_t memWriteNum_i;
    logic    memReady_i;
    logic    wbWriteEn_i;
    regNum_t wbWriteNum_i;
    word_t   wbWriteData_i;
    logic    stopFetch_o;
    logic    issueValid_o;
    word_t   pc_o;
    aluOp_t  aluOp_o;
    regNum_t writeNum_o;
    word_t   rsData_o;
    word_t   rtData_o;
    fwdSel_t fwdSel0_o;
    fwdSel_t fwdSel1_o;
    word_t   imm_o;
    logic    op1IsImm_o;
    logic    memReq_o;
    logic    memWrite_o;
    logic    isBranch_o;
    logic    reservedInst_o;

    int          testErrs;
    int          passCount;
    int          failCount;
    logic [31:0] lfsrState = 32'h2bac_33ff;

    idStage dut0 (.*);

    always #5 clk_i = ~clk_i;

    ////////////////////////////////////////////////////////////////////////////
    // encoding, random bits, expected values
    ////////////////////////////////////////////////////////////////////////////
    function automatic word_t rType(input regNum_t rs, input regNum_t rt,
                                    input regNum_t rd, input logic [5:0] fn);
        return {`ID_OP_RTYPE, rs, rt, rd, 5'd0, fn};
    endfunction

    function automatic word_t iType(input logic [5:0] op, input regNum_t rs,
                                    input regNum_t rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [15:0] randBits16();
        logic [15:0] r;
        r = '0;
        for (int i = 0; i < 16; i++) begin
            lfsrState = {lfsrState[30:0],
                         lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0]};
            r = {r[14:0], lfsrState[0]};   // one step per bit
        end
        return r;
    endfunction

    function automatic word_t extImm(input logic [5:0] op, input logic [15:0] imm);
        case (op)
            `ID_OP_ORI: return {16'h0, imm};
            `ID_OP_LUI: return {imm, 16'h0};
            default:    return {{16{imm[15]}}, imm};
        endcase
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic tick();
        @(posedge clk_i);
        #1;
    endtask

    task automatic checkVal(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Error at %0d ns: %s = %h, expected %h", $time, name, got, exp);
            testErrs++;
        end
    endtask

    task automatic checkTrue(input logic cond, input string what);
        assert (cond === 1'b1) else begin
            $display("Failure at %0d ns: %s", $time, what);
            testErrs++;
        end
    endtask

    // returns 1 ns after the push edge
    task automatic pushOne(input word_t inst, input word_t pc);
        fetchValid_i = 1'b1;
        fetchInst_i  = inst;
        fetchPc_i    = pc;
        tick();
        fetchValid_i = 1'b0;
    endtask

    task automatic wbWrite(input regNum_t num, input word_t data);
        wbWriteEn_i   = 1'b1;
        wbWriteNum_i  = num;
        wbWriteData_i = data;
        tick();
        wbWriteEn_i   = 1'b0;
    endtask

    task automatic endTest(input string name);
        if (testErrs == 0) begin
            passCount++;
            $display("%s: pass", name);
        end else begin
            failCount++;
            $display("%s: fail with %0d errors", name, testErrs);
        end
        testErrs = 0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////////////////////
    task automatic immDecodeTest();
        logic [5:0]  op;
        logic [15:0] imm;
        regNum_t     rt;
        word_t       pc;
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd0);
        checkVal("stopFetch_o", 32'(stopFetch_o), 32'd0);
        tick();
        for (int i = 0; i < 3; i++) begin
            op  = (i == 0) ? `ID_OP_ADDIU : (i == 1) ? `ID_OP_ORI : `ID_OP_LUI;
            imm = randBits16() | 16'h8000;   // sign bit set, sext and zext differ
            rt  = regNum_t'(i + 10);
            pc  = 32'h0000_1000 + 32'(i * 4);
            pushOne(iType(op, 5'd1, rt, imm), pc);
            @(negedge clk_i);
            checkVal("issueValid_o", 32'(issueValid_o), 32'd1);
            checkVal("imm_o", imm_o, extImm(op, imm));
            checkVal("writeNum_o", 32'(writeNum_o), 32'(rt));
            checkVal("op1IsImm_o", 32'(op1IsImm_o), 32'd1);
            checkVal("pc_o", pc_o, pc);
            tick();                          // issues on this edge
        end
        endTest("immediate decode");
    endtask

    task automatic regFileTest();
        word_t d5;
        word_t d6;
        word_t d8;
        d5 = {randBits16(), randBits16()};
        d6 = {randBits16(), randBits16()};
        d8 = {randBits16(), randBits16()};
        wbWrite(5'd5, d5);
        wbWrite(5'd6, d6);
        wbWrite(5'd0, {randBits16(), randBits16()});  // must be dropped
        pushOne(rType(5'd5, 5'd6, 5'd7, `ID_FN_ADDU), 32'h0000_1100);
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd1);
        checkVal("rsData_o", rsData_o, d5);
        checkVal("rtData_o", rtData_o, d6);
        checkVal("aluOp_o", 32'(aluOp_o), 32'(ALU_ADD));
        checkVal("writeNum_o", 32'(writeNum_o), 32'd7);
        tick();
        pushOne(rType(5'd8, 5'd0, 5'd9, `ID_FN_ADDU), 32'h0000_1104);
        wbWriteEn_i   = 1'b1;                // same-cycle write-back
        wbWriteNum_i  = 5'd8;
        wbWriteData_i = d8;
        @(negedge clk_i);
        checkVal("rsData_o", rsData_o, d8);
        checkVal("rtData_o", rtData_o, 32'd0);
        tick();
        wbWriteEn_i = 1'b0;
        endTest("register file");
    endtask

    task automatic forwardTest();
        exeWriteNum_i = 5'd9;
        exeReady_i    = 1'b0;
        pushOne(rType(5'd9, 5'd4, 5'd3, `ID_FN_SUBU), 32'h0000_1200);
        repeat (2) begin
            @(negedge clk_i);
            checkVal("issueValid_o", 32'(issueValid_o), 32'd0);
            tick();
        end
        exeReady_i = 1'b1;
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd1);
        checkVal("fwdSel0_o", 32'(fwdSel0_o), 32'(FWD_EXE));
        checkVal("fwdSel1_o", 32'(fwdSel1_o), 32'(FWD_REG));
        tick();
        memWriteNum_i = 5'd9;                // both stages write r9
        pushOne(rType(5'd4, 5'd9, 5'd3, `ID_FN_AND), 32'h0000_1204);
        @(negedge clk_i);
        checkVal("fwdSel0_o", 32'(fwdSel0_o), 32'(FWD_REG));
        checkVal("fwdSel1_o", 32'(fwdSel1_o), 32'(FWD_EXE));
        tick();
        exeWriteNum_i = 5'd0;
        pushOne(rType(5'd9, 5'd4, 5'd3, `ID_FN_OR), 32'h0000_1208);
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd1);
        checkVal("fwdSel0_o", 32'(fwdSel0_o), 32'(FWD_MEM));
        tick();
        memWriteNum_i = 5'd0;
        endTest("forwarding and stall");
    endtask

    task automatic backPressureTest();
        word_t expInst [$];
        word_t expPc [$];
        word_t inst;
        word_t pc;
        int    pushed;
        exeAllowin_i = 1'b0;
        pushed       = 0;
        while (!stopFetch_o && pushed < `ID_QUEUE_DEPTH) begin
            inst = iType(`ID_OP_ADDIU, 5'd2, regNum_t'(pushed + 16), randBits16());
            pc   = 32'h0000_2000 + 32'(pushed * 4);
            expInst.push_back(inst);
            expPc.push_back(pc);
            pushOne(inst, pc);
            pushed++;
        end
        checkTrue(stopFetch_o, "stopFetch_o did not rise with the queue nearly full");
        checkVal("pushes until stopFetch_o", 32'(pushed), 32'(STOP_AFTER));
        repeat (2) begin
            @(negedge clk_i);
            checkVal("issueValid_o", 32'(issueValid_o), 32'd1);
            checkVal("pc_o", pc_o, expPc[0]);   // head stays put
            tick();
        end
        exeAllowin_i = 1'b1;
        for (int i = 0; i < pushed; i++) begin
            @(negedge clk_i);
            checkVal("issueValid_o", 32'(issueValid_o), 32'd1);
            checkVal("pc_o", pc_o, expPc[i]);
            checkVal("writeNum_o", 32'(writeNum_o), 32'(expInst[i][20:16]));
            checkVal("imm_o", imm_o, extImm(`ID_OP_ADDIU, expInst[i][15:0]));
            tick();
        end
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd0);
        tick();
        endTest("back-pressure and order");
    endtask

    task automatic decodeCase(input word_t inst, input logic expMemReq,
                              input logic expMemWrite, input logic expBranch,
                              input logic expReserved, input regNum_t expWrite);
        pushOne(inst, 32'h0000_3000);
        @(negedge clk_i);
        checkVal("memReq_o", 32'(memReq_o), 32'(expMemReq));
        checkVal("memWrite_o", 32'(memWrite_o), 32'(expMemWrite));
        checkVal("isBranch_o", 32'(isBranch_o), 32'(expBranch));
        checkVal("reservedInst_o", 32'(reservedInst_o), 32'(expReserved));
        checkVal("writeNum_o", 32'(writeNum_o), 32'(expWrite));
        tick();
    endtask

    task automatic memBranchFlushTest();
        decodeCase(iType(`ID_OP_LW, 5'd3, 5'd12, randBits16()), 1, 0, 0, 0, 5'd12);
        decodeCase(iType(`ID_OP_SW, 5'd3, 5'd12, randBits16()), 1, 1, 0, 0, 5'd0);
        decodeCase(iType(`ID_OP_BEQ, 5'd3, 5'd12, randBits16()), 0, 0, 1, 0, 5'd0);
        decodeCase(iType(6'b111111, 5'd3, 5'd12, randBits16()), 0, 0, 0, 1, 5'd0);
        decodeCase(rType(5'd1, 5'd2, 5'd3, 6'b000000), 0, 0, 0, 1, 5'd0);  // sll
        exeAllowin_i = 1'b0;
        pushOne(rType(5'd1, 5'd2, 5'd3, `ID_FN_OR), 32'h0000_3100);
        pushOne(rType(5'd1, 5'd2, 5'd4, `ID_FN_SLT), 32'h0000_3104);
        flush_i = 1'b1;
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd0);
        tick();
        flush_i = 1'b0;
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd0);
        tick();
        exeAllowin_i = 1'b1;
        @(negedge clk_i);
        checkVal("issueValid_o", 32'(issueValid_o), 32'd0);   // queue was emptied
        tick();
        endTest("memory, branch, reserved and flush");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        rst_i         = 1'b1;
        flush_i       = 1'b0;
        fetchValid_i  = 1'b0;
        fetchInst_i   = '0;
        fetchPc_i     = '0;
        exeAllowin_i  = 1'b1;
        exeWriteNum_i = '0;
        exeReady_i    = 1'b1;
        memWriteNum_i = '0;
        memReady_i    = 1'b1;
        wbWriteEn_i   = 1'b0;
        wbWriteNum_i  = '0;
        wbWriteData_i = '0;
        testErrs      = 0;
        passCount     = 0;
        failCount     = 0;
        repeat (3) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        immDecodeTest();
        regFileTest();
        forwardTest();
        backPressureTest();
        memBranchFlushTest();
        $display("tests passed: %0d, failed: %0d", passCount, failCount);
        if (failCount == 0)
            $display("TEST OK");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial begin
        #(NUM_TESTS * 200 * 10);
        $display("watchdog: the tests did not finish in time");
        $display("TEST FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+rtl
rtl/idPkg.sv
rtl/idIfs.sv
rtl/instQueue.sv
rtl/decoder.sv
rtl/regFile.sv
rtl/issueCtrl.sv
rtl/idStage.sv
tests/idStage_props.sv
tests/idStageTb.sv

/* run.sh */
#!/usr/bin/env bash
# Builds the decode stage testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f --top-module idStageTb -o simv \
    && ./obj_dir/simv | tee /dev/stderr | grep -q "TEST OK" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
